//--- hdl/scrypt_defs.svh
`ifndef SCRYPT_DEFS_SVH
`define SCRYPT_DEFS_SVH

// number of parallel mixing lanes
`define SCRYPT_LANES 4

// one salsa block, sixteen words
`define SCRYPT_BLOCK_W 512
`define SCRYPT_WORD_W 32

// 4 double rounds = salsa20/8
`define SCRYPT_DROUNDS 4

`endif

//--- hdl/scrypt_pkg.sv
`include "scrypt_defs.svh"

package scrypt_pkg;

    typedef logic [`SCRYPT_BLOCK_W-1:0] block_t;
    typedef logic [`SCRYPT_WORD_W-1:0] word_t;

    // at least one bit even with a single lane
    typedef logic [((`SCRYPT_LANES > 1) ? $clog2(`SCRYPT_LANES) : 1)-1:0] lane_idx_t;

    typedef enum logic [1:0] {
        LANE_IDLE,
        LANE_MIX,
        LANE_ADD
    } lane_state_t;

    // word i (counted from the msb end) byte-reversed into bits 32i upward.
    // the mapping is its own inverse, so it serves both directions
    function automatic block_t bswap_words(block_t b);
        block_t r;
        word_t  w;
        int     nw;
        nw = `SCRYPT_BLOCK_W / `SCRYPT_WORD_W;
        r  = '0;
        for (int i = 0; i < nw; i++) begin
            w = b[`SCRYPT_BLOCK_W - `SCRYPT_WORD_W*(i+1) +: `SCRYPT_WORD_W];
            for (int j = 0; j < `SCRYPT_WORD_W/8; j++) begin
                r[`SCRYPT_WORD_W*i + 8*j +: 8] = w[`SCRYPT_WORD_W - 8*(j+1) +: 8];
            end
        end
        return r;
    endfunction

endpackage

//--- hdl/lane_if.sv
`timescale 1ns/1ns

interface lane_if;

    logic                  start;
    scrypt_pkg::block_t    block;
    logic                  busy;
    logic                  done;
    scrypt_pkg::block_t    result;

    modport dispatch (
        output start,
        output block,
        input  busy
    );

    modport lane (
        input  start,
        input  block,
        output busy,
        output done,
        output result
    );

    modport collect (
        input  done,
        input  result
    );

endinterface

//--- hdl/lane_dispatch.sv
`timescale 1ns/1ns
`include "scrypt_defs.svh"

module lane_dispatch #(
    parameter int lanes = `SCRYPT_LANES
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    input  scrypt_pkg::block_t  in_block,
    output logic                in_ready,
    lane_if.dispatch            lanes_io [lanes]
);

    scrypt_pkg::lane_idx_t  ptr;
    scrypt_pkg::block_t     salsa_block;
    logic [lanes-1:0]       busy_vec;
    logic                   accept;

    // big-endian input words to salsa word order
    assign salsa_block = scrypt_pkg::bswap_words(in_block);

    assign in_ready = !busy_vec[ptr];
    assign accept   = in_valid && in_ready;

    genvar i;
    generate
        for (i = 0; i < lanes; i++) begin : g_lane
            assign busy_vec[i]       = lanes_io[i].busy;
            assign lanes_io[i].block = salsa_block;
            // only the pointed lane sees the start
            assign lanes_io[i].start = accept && (ptr == scrypt_pkg::lane_idx_t'(i));
        end
    endgenerate

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (accept) begin
            if (ptr == scrypt_pkg::lane_idx_t'(lanes - 1)) begin
                ptr <= '0;
            end else begin
                ptr <= scrypt_pkg::lane_idx_t'(ptr + 1'b1);
            end
        end
    end

endmodule

//--- hdl/salsa_double_round.sv
`timescale 1ns/1ns

module salsa_double_round (
    input  scrypt_pkg::word_t [15:0] x_in,
    output scrypt_pkg::word_t [15:0] x_out
);

    scrypt_pkg::word_t [15:0] x;

    function automatic scrypt_pkg::word_t rotl(scrypt_pkg::word_t w, int unsigned n);
        return (w << n) | (w >> (32 - n));
    endfunction

    // one salsa quarter round on words a, b, c, d of the state
    function automatic scrypt_pkg::word_t [15:0] qr(
        scrypt_pkg::word_t [15:0] s,
        int unsigned a,
        int unsigned b,
        int unsigned c,
        int unsigned d
    );
        scrypt_pkg::word_t [15:0] t;
        t    = s;
        t[b] = t[b] ^ rotl(t[a] + t[d], 7);
        t[c] = t[c] ^ rotl(t[b] + t[a], 9);
        t[d] = t[d] ^ rotl(t[c] + t[b], 13);
        t[a] = t[a] ^ rotl(t[d] + t[c], 18);
        return t;
    endfunction

    always_comb begin
        x = x_in;

        // column round
        x = qr(x, 0, 4, 8, 12);
        x = qr(x, 5, 9, 13, 1);
        x = qr(x, 10, 14, 2, 6);
        x = qr(x, 15, 3, 7, 11);

        // row round
        x = qr(x, 0, 1, 2, 3);
        x = qr(x, 5, 6, 7, 4);
        x = qr(x, 10, 11, 8, 9);
        x = qr(x, 15, 12, 13, 14);

        x_out = x;
    end

endmodule

//--- hdl/salsa_lane.sv
`timescale 1ns/1ns
`include "scrypt_defs.svh"

module salsa_lane (
    input  logic    clk,
    input  logic    rst_n,
    lane_if.lane    lane_io
);

    localparam int RW = $clog2(`SCRYPT_DROUNDS + 1);

    scrypt_pkg::lane_state_t    state;
    logic [RW-1:0]              rnd;
    logic                       done;

    scrypt_pkg::word_t [15:0]   x_q;
    scrypt_pkg::word_t [15:0]   x0_q;
    scrypt_pkg::word_t [15:0]   dr_out;
    scrypt_pkg::word_t [15:0]   sum;

    salsa_double_round u_dround (
        .x_in   (x_q),
        .x_out  (dr_out)
    );

    // feed-forward of the saved input
    always_comb begin
        for (int i = 0; i < 16; i++) begin
            sum[i] = x_q[i] + x0_q[i];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= scrypt_pkg::LANE_IDLE;
            rnd   <= '0;
            done  <= 1'b0;
        end else begin
            done <= (state == scrypt_pkg::LANE_ADD);
            case (state)
                scrypt_pkg::LANE_IDLE: begin
                    if (lane_io.start) begin
                        state <= scrypt_pkg::LANE_MIX;
                        rnd   <= '0;
                    end
                end
                scrypt_pkg::LANE_MIX: begin
                    rnd <= rnd + 1'b1;
                    if (rnd == RW'(`SCRYPT_DROUNDS - 1)) begin
                        state <= scrypt_pkg::LANE_ADD;
                    end
                end
                default: begin
                    state <= scrypt_pkg::LANE_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            scrypt_pkg::LANE_IDLE: begin
                if (lane_io.start) begin
                    x_q  <= lane_io.block;
                    x0_q <= lane_io.block;
                end
            end
            scrypt_pkg::LANE_MIX: x_q <= dr_out;
            default:              x_q <= sum;
        endcase
    end

    // still busy while done is out, so no restart before collection
    assign lane_io.busy   = (state != scrypt_pkg::LANE_IDLE) || done;
    assign lane_io.done   = done;
    assign lane_io.result = x_q;

endmodule

//--- hdl/result_collect.sv
`timescale 1ns/1ns
`include "scrypt_defs.svh"

module result_collect #(
    parameter int lanes = `SCRYPT_LANES
) (
    input  logic                clk,
    input  logic                rst_n,
    lane_if.collect             lanes_io [lanes],
    output logic                out_valid,
    output scrypt_pkg::block_t  out_block
);

    scrypt_pkg::lane_idx_t  ptr;
    logic [lanes-1:0]       done_vec;
    scrypt_pkg::block_t     results [lanes];
    logic                   take;

    genvar i;
    generate
        for (i = 0; i < lanes; i++) begin : g_lane
            assign done_vec[i] = lanes_io[i].done;
            assign results[i]  = lanes_io[i].result;
        end
    endgenerate

    // lanes finish in dispatch order, so watch only the pointed one
    assign take = done_vec[ptr];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr       <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= take;
            if (take) begin
                if (ptr == scrypt_pkg::lane_idx_t'(lanes - 1)) begin
                    ptr <= '0;
                end else begin
                    ptr <= scrypt_pkg::lane_idx_t'(ptr + 1'b1);
                end
            end
        end
    end

    // back to big-endian word order
    always_ff @(posedge clk) begin
        if (take) begin
            out_block <= scrypt_pkg::bswap_words(results[ptr]);
        end
    end

endmodule

//--- hdl/scrypt_lanes_top.sv
`timescale 1ns/1ns
`include "scrypt_defs.svh"

module scrypt_lanes_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    input  scrypt_pkg::block_t  in_block,
    output logic                in_ready,
    output logic                out_valid,
    output scrypt_pkg::block_t  out_block
);

    lane_if lanes_if [`SCRYPT_LANES] ();

    lane_dispatch #(
        .lanes      (`SCRYPT_LANES)
    ) u_dispatch (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_block   (in_block),
        .in_ready   (in_ready),
        .lanes_io   (lanes_if)
    );

    genvar i;
    generate
        for (i = 0; i < `SCRYPT_LANES; i++) begin : g_lane
            salsa_lane u_lane (
                .clk        (clk),
                .rst_n      (rst_n),
                .lane_io    (lanes_if[i])
            );
        end
    endgenerate

    result_collect #(
        .lanes      (`SCRYPT_LANES)
    ) u_collect (
        .clk        (clk),
        .rst_n      (rst_n),
        .lanes_io   (lanes_if),
        .out_valid  (out_valid),
        .out_block  (out_block)
    );

endmodule

//--- tests/salsa_model.svh
`ifndef SALSA_MODEL_SVH
`define SALSA_MODEL_SVH

// rotate left through a doubled word
function automatic scrypt_pkg::word_t rol32(scrypt_pkg::word_t w, int n);
    logic [63:0] d;
    d = {w, w} << n;
    return d[63:32];
endfunction

// bus word i is big-endian, salsa reads it little-endian
function automatic scrypt_pkg::word_t bus_to_salsa(scrypt_pkg::block_t b, int i);
    scrypt_pkg::word_t w;
    w = b[511 - 32*i -: 32];
    return {w[7:0], w[15:8], w[23:16], w[31:24]};
endfunction

// expected out_block for a given in_block
function automatic scrypt_pkg::block_t salsa20_8_bus(scrypt_pkg::block_t bus_in);
    scrypt_pkg::word_t  x [16];
    scrypt_pkg::word_t  in_w [16];
    scrypt_pkg::word_t  w;
    scrypt_pkg::block_t r;
    for (int i = 0; i < 16; i++) begin
        in_w[i] = bus_to_salsa(bus_in, i);
        x[i]    = in_w[i];
    end
    for (int dr = 0; dr < 4; dr++) begin
        // columns
        x[4]  = x[4] ^ rol32(x[0] + x[12], 7);
        x[8]  = x[8] ^ rol32(x[4] + x[0], 9);
        x[12] = x[12] ^ rol32(x[8] + x[4], 13);
        x[0]  = x[0] ^ rol32(x[12] + x[8], 18);
        x[9]  = x[9] ^ rol32(x[5] + x[1], 7);
        x[13] = x[13] ^ rol32(x[9] + x[5], 9);
        x[1]  = x[1] ^ rol32(x[13] + x[9], 13);
        x[5]  = x[5] ^ rol32(x[1] + x[13], 18);
        x[14] = x[14] ^ rol32(x[10] + x[6], 7);
        x[2]  = x[2] ^ rol32(x[14] + x[10], 9);
        x[6]  = x[6] ^ rol32(x[2] + x[14], 13);
        x[10] = x[10] ^ rol32(x[6] + x[2], 18);
        x[3]  = x[3] ^ rol32(x[15] + x[11], 7);
        x[7]  = x[7] ^ rol32(x[3] + x[15], 9);
        x[11] = x[11] ^ rol32(x[7] + x[3], 13);
        x[15] = x[15] ^ rol32(x[11] + x[7], 18);
        // rows
        x[1]  = x[1] ^ rol32(x[0] + x[3], 7);
        x[2]  = x[2] ^ rol32(x[1] + x[0], 9);
        x[3]  = x[3] ^ rol32(x[2] + x[1], 13);
        x[0]  = x[0] ^ rol32(x[3] + x[2], 18);
        x[6]  = x[6] ^ rol32(x[5] + x[4], 7);
        x[7]  = x[7] ^ rol32(x[6] + x[5], 9);
        x[4]  = x[4] ^ rol32(x[7] + x[6], 13);
        x[5]  = x[5] ^ rol32(x[4] + x[7], 18);
        x[11] = x[11] ^ rol32(x[10] + x[9], 7);
        x[8]  = x[8] ^ rol32(x[11] + x[10], 9);
        x[9]  = x[9] ^ rol32(x[8] + x[11], 13);
        x[10] = x[10] ^ rol32(x[9] + x[8], 18);
        x[12] = x[12] ^ rol32(x[15] + x[14], 7);
        x[13] = x[13] ^ rol32(x[12] + x[15], 9);
        x[14] = x[14] ^ rol32(x[13] + x[12], 13);
        x[15] = x[15] ^ rol32(x[14] + x[13], 18);
    end
    for (int i = 0; i < 16; i++) begin
        w = x[i] + in_w[i];
        r[511 - 32*i -: 32] = {w[7:0], w[15:8], w[23:16], w[31:24]};
    end
    return r;
endfunction

`endif

//--- tests/tb_scrypt_lanes.sv
`timescale 1ns/1ns
`include "scrypt_defs.svh"

module tb_scrypt_lanes;

    localparam int WAIT_LIMIT = 200;

    logic               clk;
    logic               rst_n;
    logic               in_valid;
    scrypt_pkg::block_t in_block;
    logic               in_ready;
    logic               out_valid;
    scrypt_pkg::block_t out_block;

    // expected results in acceptance order
    scrypt_pkg::block_t exp_q [$];
    int cycle = 0;
    int acc_count = 0;
    int out_count = 0;
    int last_acc = 0;

    `include "salsa_model.svh"

    scrypt_lanes_top dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_block   (in_block),
        .in_ready   (in_ready),
        .out_valid  (out_valid),
        .out_block  (out_block)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // handshakes as seen at the DUT ports
    always @(posedge clk) begin
        if (rst_n === 1'b1 && in_valid === 1'b1 && in_ready === 1'b1) begin
            acc_count++;
        end
    end

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_block(scrypt_pkg::block_t got, scrypt_pkg::block_t exp, string what);
        if (got !== exp) begin
            $display("Error at %0t ns: %s mismatch", $time, what);
            $display("  got      %h", got);
            $display("  expected %h", exp);
            abort_run();
        end
    endtask

    task automatic check_bit(logic got, logic exp, string what);
        if (got !== exp) begin
            $display("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    // outputs settle after the rising edge, so look at the falling one
    always @(negedge clk) begin
        if (out_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("Error at %0t ns: out_valid with no block in flight", $time);
                abort_run();
            end else begin
                check_block(out_block, exp_q.pop_front(), "out_block");
                out_count++;
            end
        end
    end

    function automatic scrypt_pkg::block_t random_block();
        scrypt_pkg::block_t b;
        for (int i = 0; i < 16; i++) begin
            b[32*i +: 32] = $urandom();
        end
        return b;
    endfunction

    task automatic apply_reset();
        rst_n    = 1'b0;
        in_valid = 1'b0;
        exp_q.delete();
        repeat (3) @(negedge clk);
        rst_n = 1'b1;
    endtask

    // offer one block, keep in_valid high on return
    task automatic send_block(scrypt_pkg::block_t b, scrypt_pkg::block_t exp);
        int n;
        in_valid = 1'b1;
        in_block = b;
        n = 0;
        while (in_ready !== 1'b1 && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (in_ready !== 1'b1) begin
            $display("timeout: in_ready stayed low for %0d cycles", WAIT_LIMIT);
            abort_run();
        end
        exp_q.push_back(exp);
        last_acc = cycle + 1;
        @(negedge clk);
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout: %0d results never came out", exp_q.size());
            abort_run();
        end
        repeat (4) @(negedge clk);
    endtask

    task automatic test_after_reset();
        check_bit(in_ready, 1'b1, "in_ready after reset");
        check_bit(out_valid, 1'b0, "out_valid after reset");
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            check_bit(out_valid, 1'b0, "out_valid while idle");
        end
    endtask

    task automatic test_known_vectors();
        scrypt_pkg::block_t rfc_in;
        rfc_in = {
            128'h7e879a21_4f3ec986_7ca940e6_41718f26,
            128'hbaee555b_8c61c1b5_0df84611_6dcd3b1d,
            128'hee24f319_df9b3d85_14121e4b_5ac5aa32,
            128'h76021d29_09c74829_edebc68d_b8b8c25e
        };
        send_block('0, '0);
        in_valid = 1'b0;
        wait_drain();
        send_block(rfc_in, salsa20_8_bus(rfc_in));
        in_valid = 1'b0;
        wait_drain();
    endtask

    task automatic test_latency();
        scrypt_pkg::block_t b;
        b = random_block();
        send_block(b, salsa20_8_bus(b));
        in_valid = 1'b0;
        // one pulse, six edges after acceptance
        for (int i = 0; i < 9; i++) begin
            check_bit(out_valid, cycle == last_acc + 6, "out_valid timing");
            @(negedge clk);
        end
        wait_drain();
    endtask

    task automatic test_stream();
        scrypt_pkg::block_t b;
        for (int i = 0; i < 10; i++) begin
            b = random_block();
            send_block(b, salsa20_8_bus(b));
        end
        in_valid = 1'b0;
        wait_drain();
    endtask

    task automatic test_back_pressure();
        scrypt_pkg::block_t b;
        int acc0;
        int out0;
        acc0 = acc_count;
        out0 = out_count;
        for (int i = 0; i < `SCRYPT_LANES; i++) begin
            b = random_block();
            send_block(b, salsa20_8_bus(b));
        end
        check_bit(in_ready, 1'b0, "in_ready with all lanes busy");
        for (int i = 0; i < 2 * `SCRYPT_LANES + 1; i++) begin
            b = random_block();
            send_block(b, salsa20_8_bus(b));
        end
        in_valid = 1'b0;
        wait_drain();
        check_bit((acc_count - acc0) == (out_count - out0), 1'b1, "outputs equal acceptances");
    endtask

    task automatic test_reset_mid_stream();
        scrypt_pkg::block_t b;
        for (int i = 0; i < 2; i++) begin
            b = random_block();
            send_block(b, salsa20_8_bus(b));
        end
        apply_reset();
        check_bit(in_ready, 1'b1, "in_ready after mid-stream reset");
        for (int i = 0; i < 12; i++) begin
            @(negedge clk);
            check_bit(out_valid, 1'b0, "out_valid after mid-stream reset");
        end
        b = random_block();
        send_block(b, salsa20_8_bus(b));
        in_valid = 1'b0;
        wait_drain();
    endtask

    initial begin
        void'($urandom(14798));
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_block = '0;
        apply_reset();

        test_after_reset();
        test_known_vectors();
        test_latency();
        test_stream();
        test_back_pressure();
        test_reset_mid_stream();

        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- flist.f
+incdir+hdl
+incdir+tests
hdl/scrypt_pkg.sv
hdl/lane_if.sv
hdl/lane_dispatch.sv
hdl/salsa_double_round.sv
hdl/salsa_lane.sv
hdl/result_collect.sv
hdl/scrypt_lanes_top.sv
tests/tb_scrypt_lanes.sv

//--- Makefile
# Verilator build and run for the scrypt lane fabric testbench

VERILATOR ?= verilator
TOP       ?= tb_scrypt_lanes
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --timing --timescale 1ns/1ns

BIN     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard hdl/*.sv hdl/*.svh tests/*.sv tests/*.svh)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

# a $fatal in the testbench gives a non-zero exit status here
run: compile
	./$(BIN)

clean:
	rm -rf $(BUILD_DIR)
